// File: build.f
common/zcmp_pkg.sv
common/seq_desc_if.sv
zcmp_seq/zcmp_decoder.sv
zcmp_seq/zcmp_desc_fifo.sv
zcmp_seq/zcmp_uop_expander.sv
verilog/zcmp_seq_top.sv
dv/zcmp_seq_props.sv
dv/zcmp_seq_tb.sv

// File: dv/zcmp_seq_tb.sv
`timescale 1ns/1ps

module zcmp_seq_tb;
  import zcmp_pkg::*;

  localparam int NUM_WORDS    = 300;
  localparam int RESET_CYCLES = 8;
  // Twenty cycles per word covers the longest sequence under back-pressure
  localparam int MAX_CYCLES   = 20 * NUM_WORDS + RESET_CYCLES;

  localparam logic [6:0] OP_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_OPIMM = 7'b0010011;
  localparam logic [6:0] OP_JALR  = 7'b1100111;

  // One expected output word with its markers
  typedef struct packed {
    logic        first;
    logic        last;
    logic [31:0] word;
  } exp_t;

  logic        clk;
  logic        rst_n;
  logic [15:0] instr_i;
  logic        valid_i;
  logic        ready_o;
  logic [31:0] instr_o;
  logic        valid_o;
  logic        ready_i;
  logic        seq_first_o;
  logic        seq_last_o;

  integer seed;
  int     cycle_cnt;
  int     gap;
  exp_t   exp_q[$];
  exp_t   head;

  zcmp_seq_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_i     (instr_i),
    .valid_i     (valid_i),
    .ready_o     (ready_o),
    .instr_o     (instr_o),
    .valid_o     (valid_o),
    .ready_i     (ready_i),
    .seq_first_o (seq_first_o),
    .seq_last_o  (seq_last_o)
  );

  bind zcmp_seq_top zcmp_seq_props props0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .instr_o (instr_o),
    .valid_o (valid_o),
    .ready_i (ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // s0-s1 are x8-x9, s2 onwards starts at x18
  function automatic logic [4:0] sreg_num(input int s);
    if (s < 2) begin
      return 5'(8 + s);
    end
    return 5'(16 + s);
  endfunction

  function automatic logic [31:0] itype_word(input int imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
    logic [11:0] imm12;
    imm12 = 12'(imm);
    return {imm12, rs1, f3, rd, op};
  endfunction

  // sw rs2, imm(sp)
  function automatic logic [31:0] store_word(input int imm, input logic [4:0] rs2);
    logic [11:0] imm12;
    imm12 = 12'(imm);
    return {imm12[11:5], rs2, 5'd2, 3'b010, imm12[4:0], 7'b0100011};
  endfunction

  // Turns one accepted word into its expected output list
  task automatic expect_word(input logic [15:0] w);
    logic [31:0] seq[$];
    int          n;
    int          total;
    bit          is_push;
    if (w[1:0] != 2'b10 || w[15:13] != 3'b101) begin
      // Outside the Zcmp space nothing comes out
    end else if (w[12:10] == 3'b011) begin
      // Double move where mode 11 is mva01s and 01 is mvsa01
      if (w[5] && w[9:7] != w[4:2]) begin
        if (w[6]) begin
          seq.push_back(itype_word(0, sreg_num(w[9:7]), 3'b000, 5'd10, OP_OPIMM));
          seq.push_back(itype_word(0, sreg_num(w[4:2]), 3'b000, 5'd11, OP_OPIMM));
        end else begin
          seq.push_back(itype_word(0, 5'd10, 3'b000, sreg_num(w[9:7]), OP_OPIMM));
          seq.push_back(itype_word(0, 5'd11, 3'b000, sreg_num(w[4:2]), OP_OPIMM));
        end
      end
    end else if (w[12:11] == 2'b11 && !w[8] && w[7:4] >= 4) begin
      is_push = (w[12:9] == 4'b1100);
      n       = (w[7:4] == 15) ? 12 : w[7:4] - 4;
      // Frame of ra and n registers rounded up to 16 bytes plus the spimm frames
      total   = ((4 * (n + 1) + 15) / 16) * 16 + 16 * w[3:2];
      for (int i = 0; i <= n; i++) begin
        if (is_push) begin
          seq.push_back(store_word(-4 * (i + 1), (i == n) ? 5'd1 : sreg_num(n - 1 - i)));
        end else begin
          seq.push_back(itype_word(total - 4 * (i + 1), 5'd2, 3'b010,
                                   (i == n) ? 5'd1 : sreg_num(n - 1 - i), OP_LOAD));
        end
      end
      seq.push_back(itype_word(is_push ? -total : total, 5'd2, 3'b000, 5'd2, OP_OPIMM));
      // popretz clears a0 before returning
      if (w[12:9] == 4'b1110) begin
        seq.push_back(itype_word(0, 5'd0, 3'b000, 5'd10, OP_OPIMM));
      end
      if (w[12:10] == 3'b111) begin
        seq.push_back(itype_word(0, 5'd1, 3'b000, 5'd0, OP_JALR));
      end
    end
    foreach (seq[k]) begin
      exp_q.push_back('{first: (k == 0), last: (k == seq.size() - 1), word: seq[k]});
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_instr(input string name, input rv32_instr_u got,
                             input rv32_instr_u exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s got %b expected %b", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // Model sees every accepted word
  always @(posedge clk) begin
    if (rst_n && valid_i && ready_o) begin
      expect_word(instr_i);
    end
  end

  // Scoreboard on every output transfer
  always @(posedge clk) begin
    if (rst_n && valid_o && ready_i) begin
      if (exp_q.size() == 0) begin
        $display("DUT delivered instruction %h at %0t ns when none was due", instr_o, $time);
        $display("Finished with errors");
        $fatal(1);
      end else begin
        head = exp_q.pop_front();
        check_instr("instr_o", instr_o, head.word);
        check_flag("seq_first_o", seq_first_o, head.first);
        check_flag("seq_last_o", seq_last_o, head.last);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Finished with errors");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Mix of every kind, dropped forms and raw noise
  function automatic logic [15:0] random_word();
    logic [31:0] r;
    logic [3:0]  rlist;
    logic [2:0]  r1s;
    logic [2:0]  r2s;
    r     = $random(seed);
    rlist = 4'(4 + r[7:4] % 12);
    r1s   = r[10:8];
    r2s   = r1s + 3'(1 + r[13:11] % 7);
    case (r[19:16] % 10)
      0, 1:    return {6'b101110, 2'b00, rlist, r[3:2], 2'b10};
      2:       return {6'b101110, 2'b10, rlist, r[3:2], 2'b10};
      3:       return {6'b101111, 2'b10, rlist, r[3:2], 2'b10};
      4:       return {6'b101111, 2'b00, rlist, r[3:2], 2'b10};
      5:       return {6'b101011, r1s, 2'b11, r2s, 2'b10};
      6:       return {6'b101011, r1s, 2'b01, r2s, 2'b10};
      // rlist below 4
      7:       return {6'b101110, r[20], 1'b0, 2'b00, r[5:4], r[3:2], 2'b10};
      // equal move registers
      8:       return {6'b101011, r1s, r[20], 1'b1, r1s, 2'b10};
      default: return r[31:16];
    endcase
  endfunction

  // One clock with fresh output back-pressure
  task automatic tick();
    @(posedge clk);
    ready_i <= (($random(seed) & 3) != 0);
  endtask

  // Holds the word until the DUT takes it
  task automatic send_word(input logic [15:0] w);
    instr_i <= w;
    valid_i <= 1'b1;
    tick();
    while (!ready_o) begin
      tick();
    end
  endtask

  initial begin
    seed      = 32'h480d;
    cycle_cnt = 0;
    clk       = 1'b0;
    rst_n     = 1'b0;
    instr_i   = '0;
    valid_i   = 1'b0;
    ready_i   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < NUM_WORDS; i++) begin
      send_word(random_word());
      gap = $random(seed) & 3;
      if (gap != 0) begin
        valid_i <= 1'b0;
        repeat (gap) tick();
      end
    end
    valid_i <= 1'b0;
    while (exp_q.size() != 0) begin
      tick();
    end
    repeat (4) tick();
    if (!valid_o && dut0.props0.fail_cnt == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Run ended with valid_o %b and %0d assertion failures",
               valid_o, dut0.props0.fail_cnt);
      $display("Finished with errors");
      $fatal(1);
    end
  end

endmodule

// File: dv/zcmp_seq_props.sv
`timescale 1ns/1ps

module zcmp_seq_props (
  input logic        clk,
  input logic        rst_n,
  input logic        valid_i,
  input logic        ready_o,
  input logic [31:0] instr_o,
  input logic        valid_o,
  input logic        ready_i
);

  // Count of failed assertions
  int   fail_cnt = 0;
  // Set once the first input word has been taken
  logic seen_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      seen_q <= 1'b1;
    end
  end

  // Stalled output word stays offered and unchanged
  hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i |=> valid_o && $stable(instr_o))
    else begin
      $error("instr_o changed or was withdrawn while ready_i was low");
      fail_cnt++;
    end

  // Nothing comes out during reset or before the first accepted word
  idle_a: assert property (@(posedge clk) !seen_q |-> !valid_o)
    else begin
      $error("valid_o high before any word was accepted");
      fail_cnt++;
    end

  // Empty FIFO always takes input
  ready_a: assert property (@(posedge clk) !seen_q |-> ready_o)
    else begin
      $error("ready_o low before any word was accepted");
      fail_cnt++;
    end

endmodule

// File: verilog/zcmp_seq_top.sv
`timescale 1ns/1ps

module zcmp_seq_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] instr_i,
  input  logic        valid_i,
  output logic        ready_o,
  output logic [31:0] instr_o,
  output logic        valid_o,
  input  logic        ready_i,
  output logic        seq_first_o,
  output logic        seq_last_o
);
  import zcmp_pkg::*;

  // Decoder to FIFO, FIFO to expander
  seq_desc_if dec_if ();
  seq_desc_if exp_if ();

  // Combinational classify that drops words without a sequence
  zcmp_decoder u_decoder (
    .instr_i (instr_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .desc_o  (dec_if.producer)
  );

  // Buffers decoded words while a sequence is still running
  zcmp_desc_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_desc_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (dec_if.consumer),
    .rd    (exp_if.producer)
  );

  // One 32-bit instruction per output handshake
  zcmp_uop_expander u_uop_expander (
    .clk         (clk),
    .rst_n       (rst_n),
    .desc_i      (exp_if.consumer),
    .instr_o     (instr_o),
    .valid_o     (valid_o),
    .ready_i     (ready_i),
    .seq_first_o (seq_first_o),
    .seq_last_o  (seq_last_o)
  );

endmodule

// File: zcmp_seq/zcmp_uop_expander.sv
`timescale 1ns/1ps

module zcmp_uop_expander (
  input  logic                  clk,
  input  logic                  rst_n,
  seq_desc_if.consumer          desc_i,
  output zcmp_pkg::rv32_instr_u instr_o,
  output logic                  valid_o,
  input  logic                  ready_i,
  output logic                  seq_first_o,
  output logic                  seq_last_o
);
  import zcmp_pkg::*;

  // IDLE_S also emits the first move of a double move
  typedef enum logic [2:0] {
    IDLE_S,
    SREG_S,
    RA_S,
    SP_S,
    A0_S,
    RET_S,
    MV2_S
  } state_e;

  state_e      state_q;
  state_e      state_n;
  state_e      cur_s;
  logic [3:0]  cnt_q;
  logic [3:0]  n_saved;
  logic [3:0]  sreg_idx;
  logic [4:0]  mem_reg;
  logic [11:0] total;
  logic [11:0] step_off;
  logic [11:0] cur_off;
  logic        is_push;
  logic        is_move;
  logic        xfer;
  logic        last;

  //////////////////////////////////////////////////////////////////////
  // Sequence bookkeeping
  //////////////////////////////////////////////////////////////////////
  assign is_push = (desc_i.desc.kind == PUSH);
  assign is_move = (desc_i.desc.kind == MVA01S) || (desc_i.desc.kind == MVSA01);
  assign n_saved = regs_saved(desc_i.desc.rlist);
  assign total   = stack_adj_base(desc_i.desc.rlist) + {6'd0, desc_i.desc.spimm, 4'd0};

  // Every step moves four bytes further from the start
  assign step_off = {6'd0, cnt_q, 2'b00} + 12'd4;
  // Push walks down from sp, pops walk down from the old frame top
  assign cur_off  = is_push ? 12'd0 - step_off : total - step_off;
  // Highest s-register goes first
  assign sreg_idx = n_saved - 4'd1 - cnt_q;

  // Push/pop start straight at their first memory access
  assign cur_s = (state_q == IDLE_S && !is_move) ?
                 ((n_saved != 4'd0) ? SREG_S : RA_S) : state_q;
  assign mem_reg = (cur_s == SREG_S) ? sreg_to_regnum(sreg_idx) : REG_RA;

  // Descriptor stays in the FIFO until the whole sequence is out
  assign valid_o = desc_i.valid;
  assign xfer    = valid_o && ready_i;

  //////////////////////////////////////////////////////////////////////
  // Instruction build and next state
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    instr_o = '0;
    state_n = cur_s;
    last    = 1'b0;
    case (cur_s)
      SREG_S, RA_S: begin
        if (is_push) begin
          // sw reg, off(sp)
          instr_o.stype.imm_hi = cur_off[11:5];
          instr_o.stype.rs2    = mem_reg;
          instr_o.stype.rs1    = REG_SP;
          instr_o.stype.funct3 = 3'b010;
          instr_o.stype.imm_lo = cur_off[4:0];
          instr_o.stype.opcode = OPCODE_STORE;
        end else begin
          // lw reg, off(sp)
          instr_o.itype.imm12  = cur_off;
          instr_o.itype.rs1    = REG_SP;
          instr_o.itype.funct3 = 3'b010;
          instr_o.itype.rd     = mem_reg;
          instr_o.itype.opcode = OPCODE_LOAD;
        end
        if (cur_s == RA_S) begin
          state_n = SP_S;
        end else if (cnt_q == n_saved - 4'd1) begin
          state_n = RA_S;
        end
      end
      SP_S: begin
        // addi sp, sp, +/-total
        instr_o.itype.imm12  = is_push ? 12'd0 - total : total;
        instr_o.itype.rs1    = REG_SP;
        instr_o.itype.rd     = REG_SP;
        instr_o.itype.opcode = OPCODE_OPIMM;
        if (desc_i.desc.kind == POPRETZ) begin
          state_n = A0_S;
        end else if (desc_i.desc.kind == POPRET) begin
          state_n = RET_S;
        end else begin
          state_n = IDLE_S;
          last    = 1'b1;
        end
      end
      A0_S: begin
        // addi a0, x0, 0
        instr_o.itype.rs1    = REG_ZERO;
        instr_o.itype.rd     = REG_A0;
        instr_o.itype.opcode = OPCODE_OPIMM;
        state_n = RET_S;
      end
      RET_S: begin
        // jalr x0, 0(ra)
        instr_o.itype.rs1    = REG_RA;
        instr_o.itype.rd     = REG_ZERO;
        instr_o.itype.opcode = OPCODE_JALR;
        state_n = IDLE_S;
        last    = 1'b1;
      end
      MV2_S: begin
        // Second move pairs a1 with r2s
        instr_o.itype.opcode = OPCODE_OPIMM;
        if (desc_i.desc.kind == MVA01S) begin
          instr_o.itype.rs1 = sreg_to_regnum({1'b0, desc_i.desc.r2s});
          instr_o.itype.rd  = REG_A1;
        end else begin
          instr_o.itype.rs1 = REG_A1;
          instr_o.itype.rd  = sreg_to_regnum({1'b0, desc_i.desc.r2s});
        end
        state_n = IDLE_S;
        last    = 1'b1;
      end
      default: begin
        // First move pairs a0 with r1s
        instr_o.itype.opcode = OPCODE_OPIMM;
        if (desc_i.desc.kind == MVA01S) begin
          instr_o.itype.rs1 = sreg_to_regnum({1'b0, desc_i.desc.r1s});
          instr_o.itype.rd  = REG_A0;
        end else begin
          instr_o.itype.rs1 = REG_A0;
          instr_o.itype.rd  = sreg_to_regnum({1'b0, desc_i.desc.r1s});
        end
        state_n = MV2_S;
      end
    endcase
  end

  assign seq_first_o = valid_o && (state_q == IDLE_S);
  assign seq_last_o  = valid_o && last;
  // Pop the descriptor together with its last instruction
  assign desc_i.ready = xfer && last;

  // State and counter only move on an output transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE_S;
      cnt_q   <= '0;
    end else if (xfer) begin
      state_q <= state_n;
      cnt_q   <= last ? 4'd0 : cnt_q + 4'd1;
    end
  end

endmodule

// File: zcmp_seq/zcmp_desc_fifo.sv
`timescale 1ns/1ps

module zcmp_desc_fifo #(
  parameter int DEPTH = zcmp_pkg::FIFO_DEPTH
) (
  input  logic         clk,
  input  logic         rst_n,
  seq_desc_if.consumer wr,
  seq_desc_if.producer rd
);
  import zcmp_pkg::*;

  // Descriptor storage
  seq_desc_t                    mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]   count;
  logic                         push;
  logic                         pop;

  // Full blocks writes, empty hides the read side
  assign wr.ready = (int'(count) != DEPTH);
  assign rd.valid = (count != '0);
  assign rd.desc  = mem[rd_ptr];

  assign push = wr.valid && wr.ready;
  assign pop  = rd.valid && rd.ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr.desc;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pointers and fill level
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Explicit wrap so any depth works
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together leave the count unchanged
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: zcmp_seq/zcmp_decoder.sv
`timescale 1ns/1ps

module zcmp_decoder (
  input  zcmp_pkg::cinstr_u instr_i,
  input  logic              valid_i,
  output logic              ready_o,
  seq_desc_if.producer      desc_o
);
  import zcmp_pkg::*;

  logic      legal;
  seq_kind_e kind;

  //////////////////////////////////////////////////////////////////////
  // Classify the compressed word
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    legal = 1'b0;
    kind  = PUSH;
    // All Zcmp sequences sit in quadrant 2 under funct3 101
    if (instr_i.pp.op == 2'b10 && instr_i.pp.funct3 == 3'b101) begin
      case (instr_i.pp.funct3_sub)
        3'b011: begin
          // Double moves need two distinct s-registers
          if (instr_i.mv.r1s != instr_i.mv.r2s) begin
            if (instr_i.mv.mode == 2'b11) begin
              legal = 1'b1;
              kind  = MVA01S;
            end else if (instr_i.mv.mode == 2'b01) begin
              legal = 1'b1;
              kind  = MVSA01;
            end
          end
        end
        3'b110: begin
          // push (00) or pop (10)
          if (instr_i.pp.rlist > 4'd3 && !instr_i.pp.funct2[0]) begin
            legal = 1'b1;
            kind  = instr_i.pp.funct2[1] ? POP : PUSH;
          end
        end
        3'b111: begin
          // popretz (00) or popret (10)
          if (instr_i.pp.rlist > 4'd3 && !instr_i.pp.funct2[0]) begin
            legal = 1'b1;
            kind  = instr_i.pp.funct2[1] ? POPRET : POPRETZ;
          end
        end
        default: begin
          legal = 1'b0;
        end
      endcase
    end
  end

  // Descriptor fields come from both views, kind selects which matter
  assign desc_o.desc.kind  = kind;
  assign desc_o.desc.rlist = instr_i.pp.rlist;
  assign desc_o.desc.spimm = instr_i.pp.spimm;
  assign desc_o.desc.r1s   = instr_i.mv.r1s;
  assign desc_o.desc.r2s   = instr_i.mv.r2s;

  assign desc_o.valid = valid_i && legal;
  // Words without a sequence are swallowed right away
  assign ready_o = legal ? desc_o.ready : 1'b1;

endmodule

// File: common/seq_desc_if.sv
`timescale 1ns/1ps

// Valid/ready channel carrying one decoded descriptor
interface seq_desc_if;
  import zcmp_pkg::*;

  // Producer holds desc stable while valid is high and ready is low
  logic      valid;
  logic      ready;
  seq_desc_t desc;

  // Side that offers descriptors
  modport producer (
    output valid,
    output desc,
    input  ready
  );

  // Side that takes descriptors
  modport consumer (
    input  valid,
    input  desc,
    output ready
  );

endinterface

// File: common/zcmp_pkg.sv
package zcmp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////

  // Descriptor FIFO depth, lets one word decode while another expands
  localparam int FIFO_DEPTH = 2;

  // Architectural register numbers
  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;
  localparam logic [4:0] REG_A0   = 5'd10;
  localparam logic [4:0] REG_A1   = 5'd11;

  // RV32 major opcodes
  localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE = 7'b0100011;
  localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;
  localparam logic [6:0] OPCODE_JALR  = 7'b1100111;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // Instructions that expand into a sequence
  typedef enum logic [2:0] {
    PUSH,
    POP,
    POPRET,
    POPRETZ,
    MVA01S,
    MVSA01
  } seq_kind_e;

  // Compressed word, push/pop layout or double-move layout
  typedef union packed {
    struct packed {
      logic [2:0] funct3;
      logic [2:0] funct3_sub;
      logic [1:0] funct2;
      logic [3:0] rlist;
      logic [1:0] spimm;
      logic [1:0] op;
    } pp;
    struct packed {
      logic [2:0] funct3;
      logic [2:0] funct3_sub;
      logic [2:0] r1s;
      logic [1:0] mode;
      logic [2:0] r2s;
      logic [1:0] op;
    } mv;
  } cinstr_u;

  // One decoded instruction waiting for expansion
  typedef struct packed {
    seq_kind_e  kind;
    logic [3:0] rlist;
    logic [1:0] spimm;
    logic [2:0] r1s;
    logic [2:0] r2s;
  } seq_desc_t;

  // Emitted 32-bit word, built as I-type or S-type
  typedef union packed {
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } itype;
    struct packed {
      logic [6:0]  imm_hi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
    } stype;
  } rv32_instr_u;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Number of s-registers in rlist, s10 is never saved alone
  function automatic logic [3:0] regs_saved(input logic [3:0] rlist);
    return (rlist == 4'd15) ? 4'd12 : rlist - 4'd4;
  endfunction

  // Bytes for ra plus saved registers, 16-byte aligned
  function automatic logic [11:0] stack_adj_base(input logic [3:0] rlist);
    logic [11:0] bytes;
    bytes = {6'd0, regs_saved(rlist), 2'b00} + 12'd4;
    return (bytes + 12'd15) & 12'hff0;
  endfunction

  // s0-s1 live at x8-x9, s2-s11 at x18-x27
  function automatic logic [4:0] sreg_to_regnum(input logic [3:0] sreg);
    return (sreg < 4'd2) ? {1'b0, sreg} + 5'd8 : {1'b0, sreg} + 5'd16;
  endfunction

endpackage
